// File: robSubsystem.f
robPkg.sv
redirectPkg.sv
resultStage.sv
reorderBuffer.sv
commitUnit.sv
robSubsystem.sv
robSubsystem_assert.sv
robSubsystem_tb.sv

// File: Bender.yml
package:
  name: robSubsystem

sources:
  - robPkg.sv
  - redirectPkg.sv
  - resultStage.sv
  - reorderBuffer.sv
  - commitUnit.sv
  - robSubsystem.sv
  - target: test
    files:
      - robSubsystem_assert.sv
      - robSubsystem_tb.sv

// File: robSubsystem_tb.sv
`timescale 1ns/1ns

module robSubsystem_tb
    import robPkg::*;
    import redirectPkg::*;
();

    localparam int LENGTH = 32;
    localparam int WIDTH = 3;
    localparam int WIDTH_WB = 3;
    // seven short tests of well under 100 cycles each, so 4000 is generous
    localparam int TIMEOUT_CYCLES = 4000;

    logic clk;
    logic rst;
    ResultUop resultIn[WIDTH_WB-1:0];
    Squash mispredict;
    logic [31:0] irqAddr;
    logic [5:0] mapIdx;
    CommitUop commitOut[WIDTH-1:0];
    Redirect redirect;
    IrqInfo irqInfo;
    SqN maxSqN;
    SqN curSqN;
    logic [6:0] mapTag;
    logic [31:0] retired;

    CommitUop expQ[$];
    ResultUop sendQ[$];
    logic [6:0] refMap[64];
    logic refWritten[64];
    logic [31:0] rng = 32'hc35a4f70;
    SqN nextSqN;
    int errors;
    int totalExp;
    int cycleCount;
    int assertFails;
    string testName;

    robSubsystem #(.LENGTH(LENGTH), .WIDTH(WIDTH), .WIDTH_WB(WIDTH_WB)) DUT (.*);

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // unflagged result with random name, tag and word aligned pc
    function automatic ResultUop randomUop(SqN s);
        ResultUop u;
        rng = xorshift32(rng);
        u = '0;
        u.valid = 1'b1;
        u.sqN = s;
        u.nmDst = 6'(rng[2:0]);
        u.tagDst = rng[9:3];
        rng = xorshift32(rng);
        u.pc = {rng[31:2], 2'b00};
        return u;
    endfunction

    // expected commit in program order, plus its effect on the map
    task automatic expectUop(ResultUop u);
        CommitUop c;
        c = '{1'b1, u.flags, u.nmDst, u.tagDst, u.sqN, u.pc[31:2],
              u.isBranch, u.branchTaken, u.branchID};
        expQ.push_back(c);
        totalExp++;
        if (u.flags == flagsNone || u.flags == flagsTrap) begin
            refMap[u.nmDst] = u.tagDst;
            refWritten[u.nmDst] = 1'b1;
        end
    endtask

    task automatic sendBurst(int perCycle);
        while (sendQ.size() > 0) begin
            @(posedge clk);
            #1;
            for (int i = 0; i < WIDTH_WB; i++) begin
                resultIn[i] = '0;
                if (i < perCycle && sendQ.size() > 0) begin
                    resultIn[i] = sendQ.pop_front();
                end
            end
        end
        @(posedge clk);
        #1;
        for (int i = 0; i < WIDTH_WB; i++) begin
            resultIn[i] = '0;
        end
    endtask

    // all expected commits seen
    task automatic drain();
        do begin
            @(posedge clk);
            #1;
        end while (expQ.size() != 0);
    endtask

    task automatic checkMap();
        for (int n = 0; n < 64; n++) begin
            if (refWritten[n]) begin
                @(posedge clk);
                #1;
                mapIdx = 6'(n);
                #1;
                if (mapTag !== refMap[n]) begin
                    $display("CHECK FAILED %s: mapTag[%0d] expected %h actual %h",
                             testName, n, refMap[n], mapTag);
                    errors++;
                end
            end
        end
    endtask

    always @(negedge clk) begin : monitor
        CommitUop expC;
        if (!rst) begin
            for (int i = 0; i < WIDTH; i++) begin
                if (commitOut[i].valid && expQ.size() == 0) begin
                    $display("test %s: sqN %0d committed but nothing was outstanding",
                             testName, commitOut[i].sqN);
                    errors++;
                end else if (commitOut[i].valid) begin
                    expC = expQ.pop_front();
                    if (commitOut[i] !== expC) begin
                        $display("CHECK FAILED %s: commit expected %h actual %h",
                                 testName, expC, commitOut[i]);
                        errors++;
                    end
                end
                if (i > 0 && commitOut[i].valid && commitOut[i].isBranch) begin
                    $display("test %s: branch committed in lane %0d behind the head",
                             testName, i);
                    errors++;
                end
            end
        end
    end

    task automatic inOrderTest();
        ResultUop u;
        testName = "inOrder";
        for (int i = 0; i < 20; i++) begin
            u = randomUop(nextSqN);
            expectUop(u);
            sendQ.push_back(u);
            nextSqN++;
        end
        sendBurst(3);
        drain();
        if (retired !== 32'(totalExp)) begin
            $display("CHECK FAILED %s: retired expected %0d actual %0d",
                     testName, totalExp, retired);
            errors++;
        end
        if (curSqN !== SqN'(totalExp)) begin
            $display("CHECK FAILED %s: curSqN expected %0d actual %0d",
                     testName, SqN'(totalExp), curSqN);
            errors++;
        end
        // free-slot bound sits three short of a full window past the head
        if (maxSqN !== SqN'(totalExp + LENGTH - 3)) begin
            $display("CHECK FAILED %s: maxSqN expected %0d actual %0d",
                     testName, SqN'(totalExp + LENGTH - 3), maxSqN);
            errors++;
        end
        checkMap();
    endtask

    task automatic outOfOrderTest();
        ResultUop u;
        ResultUop batch[$];
        int j;
        testName = "outOfOrder";
        // 24 stays inside the free-slot bound of curSqN + 29
        for (int i = 0; i < 24; i++) begin
            u = randomUop(nextSqN);
            expectUop(u);
            batch.push_back(u);
            nextSqN++;
        end
        for (int i = batch.size() - 1; i > 0; i--) begin
            rng = xorshift32(rng);
            j = int'(rng % (i + 1));
            u = batch[i];
            batch[i] = batch[j];
            batch[j] = u;
        end
        sendQ = batch;
        sendBurst(3);
        drain();
    endtask

    task automatic branchTest();
        ResultUop u;
        testName = "branch";
        for (int i = 0; i < 9; i++) begin
            u = randomUop(nextSqN);
            // one behind the head, and later two behind it
            if (i == 1 || i == 6) begin
                rng = xorshift32(rng);
                u.isBranch = 1'b1;
                u.branchTaken = rng[0];
                u.branchID = rng[6:1];
            end
            expectUop(u);
            sendQ.push_back(u);
            nextSqN++;
        end
        sendBurst(3);
        drain();
    endtask

    // flagged entry second, three younger results behind it
    task automatic flaggedTest(Flags f, string name);
        ResultUop u;
        logic [29:0] wpc;
        testName = name;
        for (int i = 0; i < 5; i++) begin
            u = randomUop(nextSqN + SqN'(i));
            u.nmDst = 6'd9;
            if (i == 1) begin
                u.flags = f;
                wpc = u.pc[31:2];
            end
            if (i < 2) begin
                expectUop(u);
            end
            sendQ.push_back(u);
        end
        nextSqN = nextSqN + SqN'(2);
        sendBurst(3);
        do begin
            @(posedge clk);
            #1;
        end while (!redirect.taken);
        if (f == flagsBrk) begin
            if ({redirect.halt, redirect.dstPc} !== {1'b1, {wpc, 2'b00} + 32'd4}) begin
                $display("CHECK FAILED %s: halt,dstPc expected %h actual %h", testName,
                         {1'b1, {wpc, 2'b00} + 32'd4}, {redirect.halt, redirect.dstPc});
                errors++;
            end
        end else if ({redirect.halt, redirect.dstPc, irqInfo.src, irqInfo.flags} !==
                     {1'b0, irqAddr, wpc, 2'b00, f}) begin
            $display("CHECK FAILED %s: halt,dstPc,src,flags expected %h actual %h",
                     testName, {1'b0, irqAddr, wpc, 2'b00, f},
                     {redirect.halt, redirect.dstPc, irqInfo.src, irqInfo.flags});
            errors++;
        end
        drain();
        checkMap();
    endtask

    task automatic mispredictTest();
        ResultUop batch[6];
        SqN k;
        testName = "mispredict";
        k = nextSqN + SqN'(2);
        for (int i = 0; i < 6; i++) begin
            batch[i] = randomUop(nextSqN + SqN'(i));
            if (i < 3) begin
                expectUop(batch[i]);
            end
        end
        // head held back so nothing retires before the squash
        for (int i = 1; i < 6; i++) begin
            sendQ.push_back(batch[i]);
        end
        sendBurst(3);
        mispredict = '{1'b1, k};
        @(posedge clk);
        #1;
        mispredict = '0;
        sendQ.push_back(batch[0]);
        sendBurst(3);
        nextSqN = k + SqN'(1);
        drain();
        for (int i = 0; i < 6; i++) begin
            batch[i] = randomUop(nextSqN);
            expectUop(batch[i]);
            sendQ.push_back(batch[i]);
            nextSqN++;
        end
        sendBurst(3);
        drain();
        checkMap();
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, test %s never finished", cycleCount, testName);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        mispredict = '0;
        mapIdx = '0;
        for (int i = 0; i < WIDTH_WB; i++) begin
            resultIn[i] = '0;
        end
        for (int n = 0; n < 64; n++) begin
            refWritten[n] = 1'b0;
        end
        errors = 0;
        totalExp = 0;
        nextSqN = '0;
        testName = "reset";
        rng = xorshift32(rng);
        irqAddr = {rng[31:2], 2'b00};
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        inOrderTest();
        outOfOrderTest();
        branchTest();
        flaggedTest(flagsTrap, "trap");
        flaggedTest(flagsExcept, "exception");
        flaggedTest(flagsBrk, "breakpoint");
        mispredictTest();
        testName = "final";
        if (retired !== 32'(totalExp)) begin
            $display("CHECK FAILED %s: retired expected %0d actual %0d",
                     testName, totalExp, retired);
            errors++;
        end
        assertFails = DUT.commitUnitInst.commitAssert.failCount;
        $display("%0d check errors, %0d assertion failures", errors, assertFails);
        if (errors == 0 && assertFails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: robSubsystem_assert.sv
`timescale 1ns/1ns

module robSubsystem_assert
    import robPkg::*;
    import redirectPkg::*;
#(
    parameter int WIDTH = 3
)
(
    input logic clk,
    input logic rst,
    input CommitUop commitUops[WIDTH-1:0],
    input Redirect redirect
);

    int failCount = 0;
    logic [WIDTH-1:0] laneValid;

    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            laneValid[i] = commitUops[i].valid;
        end
    end

    for (genvar i = 1; i < WIDTH; i++) begin : gLane
        // valid lanes form a prefix from lane 0
        assert property (@(posedge clk) disable iff (rst) laneValid[i] |-> laneValid[i-1])
        else begin
            failCount++;
            $error("commit lane %0d valid without lane %0d", i, i - 1);
        end
        assert property (@(posedge clk) disable iff (rst)
            laneValid[i] |-> commitUops[i].sqN == SqN'(commitUops[i-1].sqN + 6'd1))
        else begin
            failCount++;
            $error("commit lane %0d sqN does not follow lane %0d", i, i - 1);
        end
    end

    // halt only follows a breakpoint commit in lane 0
    assert property (@(posedge clk) disable iff (rst)
        redirect.halt |-> redirect.taken && $past(commitUops[0].valid) &&
            $past(commitUops[0].flags) == flagsBrk)
    else begin
        failCount++;
        $error("halt raised without a taken redirect from a breakpoint commit");
    end

    // nothing commits straight out of reset
    assert property (@(posedge clk) rst |=> laneValid == '0)
    else begin
        failCount++;
        $error("commit lane valid in the cycle after reset");
    end

endmodule

bind commitUnit robSubsystem_assert #(.WIDTH(WIDTH)) commitAssert (
    .clk(clk),
    .rst(rst),
    .commitUops(commitUops),
    .redirect(redirect)
);

// File: robSubsystem.sv
`timescale 1ns/1ns

module robSubsystem
    import robPkg::*;
    import redirectPkg::*;
#(
    parameter int LENGTH = 32,
    parameter int WIDTH = 3,
    parameter int WIDTH_WB = 3
)
(
    input logic clk,
    input logic rst,
    input ResultUop resultIn[WIDTH_WB-1:0],
    input Squash mispredict,
    input logic [31:0] irqAddr,
    input logic [5:0] mapIdx,
    output CommitUop commitOut[WIDTH-1:0],
    output Redirect redirect,
    output IrqInfo irqInfo,
    output SqN maxSqN,
    output SqN curSqN,
    output logic [6:0] mapTag,
    output logic [31:0] retired
);

    ResultUop stagedUops[WIDTH_WB-1:0];
    CommitUop commitUops[WIDTH-1:0];
    Squash squash;

    assign commitOut = commitUops;

    resultStage #(
        .WIDTH_WB(WIDTH_WB)
    ) resultStageInst (
        .clk(clk),
        .rst(rst),
        .resultIn(resultIn),
        .squash(squash),
        .stagedUops(stagedUops)
    );

    reorderBuffer #(
        .LENGTH(LENGTH),
        .WIDTH(WIDTH),
        .WIDTH_WB(WIDTH_WB)
    ) reorderBufferInst (
        .clk(clk),
        .rst(rst),
        .stagedUops(stagedUops),
        .squash(squash),
        .commitUops(commitUops),
        .curSqN(curSqN),
        .maxSqN(maxSqN)
    );

    commitUnit #(
        .WIDTH(WIDTH)
    ) commitUnitInst (
        .clk(clk),
        .rst(rst),
        .commitUops(commitUops),
        .mispredict(mispredict),
        .irqAddr(irqAddr),
        .mapIdx(mapIdx),
        .squash(squash),
        .redirect(redirect),
        .irqInfo(irqInfo),
        .mapTag(mapTag),
        .retired(retired)
    );

endmodule

// File: commitUnit.sv
`timescale 1ns/1ns

module commitUnit
    import robPkg::*;
    import redirectPkg::*;
#(
    parameter int WIDTH = 3
)
(
    input logic clk,
    input logic rst,
    input CommitUop commitUops[WIDTH-1:0],
    input Squash mispredict,
    input logic [31:0] irqAddr,
    input logic [5:0] mapIdx,
    output Squash squash,
    output Redirect redirect,
    output IrqInfo irqInfo,
    output logic [6:0] mapTag,
    output logic [31:0] retired
);

    // committed name to tag map
    logic [6:0] committedMap[64];
    SqN flushSqN;
    logic [31:0] laneCount;

    assign mapTag = committedMap[mapIdx];

    // later lanes are younger and override earlier writes to the same name
    always_ff @(posedge clk) begin
        for (int i = 0; i < WIDTH; i++) begin
            if (commitUops[i].valid &&
                (commitUops[i].flags == flagsNone || commitUops[i].flags == flagsTrap)) begin
                committedMap[commitUops[i].nmDst] <= commitUops[i].tagDst;
            end
        end
    end

    always_comb begin
        laneCount = '0;
        for (int i = 0; i < WIDTH; i++) begin
            laneCount = laneCount + 32'(commitUops[i].valid);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retired <= '0;
        end else begin
            retired <= retired + laneCount;
        end
    end

    // flagged entries only ever retire alone, in lane 0
    always_ff @(posedge clk) begin
        if (rst) begin
            redirect.taken <= 1'b0;
            redirect.halt <= 1'b0;
        end else begin
            redirect.taken <= 1'b0;
            redirect.halt <= 1'b0;
            if (commitUops[0].valid && commitUops[0].flags != flagsNone) begin
                redirect.taken <= 1'b1;
                flushSqN <= commitUops[0].sqN;
                if (commitUops[0].flags == flagsBrk) begin
                    // resume after the breakpoint itself
                    redirect.halt <= 1'b1;
                    redirect.dstPc <= {commitUops[0].pc + 30'd1, 2'b00};
                end else begin
                    redirect.dstPc <= irqAddr;
                    irqInfo.flags <= commitUops[0].flags;
                    irqInfo.src <= {commitUops[0].pc, 2'b00};
                    // name and branch fields carry the faulting address segment
                    irqInfo.memAddr <= {commitUops[0].nmDst, commitUops[0].branchTaken,
                                        commitUops[0].branchID};
                end
            end
        end
    end

    // merge own flush with the external mispredict, older sqN wins
    always_comb begin
        squash = mispredict;
        if (redirect.taken && !(mispredict.valid && isYounger(flushSqN, mispredict.sqN))) begin
            squash.valid = 1'b1;
            squash.sqN = flushSqN;
        end
    end

endmodule

// File: reorderBuffer.sv
`timescale 1ns/1ns

module reorderBuffer
    import robPkg::*;
    import redirectPkg::*;
#(
    parameter int LENGTH = 32,
    parameter int WIDTH = 3,
    parameter int WIDTH_WB = 3
)
(
    input logic clk,
    input logic rst,
    input ResultUop stagedUops[WIDTH_WB-1:0],
    input Squash squash,
    output CommitUop commitUops[WIDTH-1:0],
    output SqN curSqN,
    output SqN maxSqN
);

    localparam int IDX = $clog2(LENGTH);

    // slot index is taken from the low sqN bits
    if (LENGTH > 32 || LENGTH < 2 || (LENGTH & (LENGTH - 1)) != 0) begin : gLengthCheck
        $error("LENGTH must be a power of two no larger than 32");
    end

    RobEntry entries[LENGTH-1:0];
    SqN baseIndex;
    logic [IDX-1:0] slot[WIDTH-1:0];
    logic groupOk;
    logic headOk;
    // a flagged entry retired, hold until its flush arrives
    logic trapPending;

    assign curSqN = baseIndex;
    // three slots kept in reserve for results already in flight
    assign maxSqN = baseIndex + SqN'(LENGTH - 3);

    function automatic RobEntry toEntry(ResultUop r);
        RobEntry e;
        e.valid = 1'b1;
        e.flags = r.flags;
        e.tagDst = r.tagDst;
        e.nmDst = r.nmDst;
        e.sqN = r.sqN;
        e.pc = r.pc[31:2];
        e.isBranch = r.isBranch;
        e.branchTaken = r.branchTaken;
        e.branchID = r.branchID;
        return e;
    endfunction

    function automatic CommitUop toCommit(RobEntry e);
        CommitUop c;
        c.valid = 1'b1;
        c.flags = e.flags;
        c.nmDst = e.nmDst;
        c.tagDst = e.tagDst;
        c.sqN = e.sqN;
        c.pc = e.pc;
        c.isBranch = e.isBranch;
        c.branchTaken = e.branchTaken;
        c.branchID = e.branchID;
        return c;
    endfunction

    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            slot[i] = baseIndex[IDX-1:0] + IDX'(i);
        end
    end

    // full group only when every entry is ready, unflagged and
    // no branch sits behind the head
    always_comb begin
        groupOk = 1'b1;
        for (int i = 0; i < WIDTH; i++) begin
            if (!entries[slot[i]].valid || entries[slot[i]].flags != flagsNone) begin
                groupOk = 1'b0;
            end
            if (i > 0 && entries[slot[i]].isBranch) begin
                groupOk = 1'b0;
            end
        end
        headOk = entries[slot[0]].valid;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            baseIndex <= '0;
            trapPending <= 1'b0;
            for (int i = 0; i < LENGTH; i++) begin
                entries[i].valid <= 1'b0;
            end
            for (int i = 0; i < WIDTH; i++) begin
                commitUops[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < WIDTH; i++) begin
                commitUops[i].valid <= 1'b0;
            end

            if (squash.valid) begin
                trapPending <= 1'b0;
                for (int i = 0; i < LENGTH; i++) begin
                    if (isYounger(entries[i].sqN, squash.sqN)) begin
                        entries[i].valid <= 1'b0;
                    end
                end
            end else if (!trapPending && groupOk) begin
                for (int i = 0; i < WIDTH; i++) begin
                    commitUops[i] <= toCommit(entries[slot[i]]);
                    entries[slot[i]].valid <= 1'b0;
                end
                baseIndex <= baseIndex + SqN'(WIDTH);
            end else if (!trapPending && headOk) begin
                commitUops[0] <= toCommit(entries[slot[0]]);
                entries[slot[0]].valid <= 1'b0;
                baseIndex <= baseIndex + SqN'(1);
                if (entries[slot[0]].flags != flagsNone) begin
                    trapPending <= 1'b1;
                end
            end

            // squashed lanes were already dropped upstream
            for (int i = 0; i < WIDTH_WB; i++) begin
                if (stagedUops[i].valid) begin
                    entries[stagedUops[i].sqN[IDX-1:0]] <= toEntry(stagedUops[i]);
                end
            end
        end
    end

endmodule

// File: resultStage.sv
`timescale 1ns/1ns

module resultStage
    import robPkg::*;
    import redirectPkg::*;
#(
    parameter int WIDTH_WB = 3
)
(
    input logic clk,
    input logic rst,
    input ResultUop resultIn[WIDTH_WB-1:0],
    input Squash squash,
    output ResultUop stagedUops[WIDTH_WB-1:0]
);

    ResultUop laneReg[WIDTH_WB-1:0];

    // true when the squash in this cycle kills a result with this sqN
    function automatic logic killed(SqN sqN);
        return squash.valid && isYounger(sqN, squash.sqN);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < WIDTH_WB; i++) begin
                laneReg[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < WIDTH_WB; i++) begin
                laneReg[i] <= resultIn[i];
                // stale on arrival
                laneReg[i].valid <= resultIn[i].valid && !killed(resultIn[i].sqN);
            end
        end
    end

    // a squash can also hit a result while it sits in the register
    always_comb begin
        for (int i = 0; i < WIDTH_WB; i++) begin
            stagedUops[i] = laneReg[i];
            stagedUops[i].valid = laneReg[i].valid && !killed(laneReg[i].sqN);
        end
    end

endmodule

// File: redirectPkg.sv
package redirectPkg;

    import robPkg::*;

    // discard everything younger than sqN
    typedef struct packed {
        logic valid;
        SqN sqN;
    } Squash;

    // fetch redirect
    typedef struct packed {
        logic taken;
        logic halt;
        logic [31:0] dstPc;
    } Redirect;

    // trap cause
    typedef struct packed {
        Flags flags;
        logic [31:0] src;
        logic [12:0] memAddr;
    } IrqInfo;

endpackage

// File: robPkg.sv
package robPkg;

    // sequence number, compared through the signed difference
    typedef logic [5:0] SqN;

    typedef enum logic [1:0] {
        flagsNone,
        flagsTrap,
        flagsExcept,
        flagsBrk
    } Flags;

    // one writeback result as delivered by execution
    typedef struct packed {
        logic valid;
        Flags flags;
        logic [6:0] tagDst;
        logic [5:0] nmDst;
        SqN sqN;
        logic [31:0] pc;
        logic isBranch;
        logic branchTaken;
        logic [5:0] branchID;
    } ResultUop;

    // one buffer slot, pc kept as a word address
    typedef struct packed {
        logic valid;
        Flags flags;
        logic [6:0] tagDst;
        logic [5:0] nmDst;
        SqN sqN;
        logic [29:0] pc;
        logic isBranch;
        logic branchTaken;
        logic [5:0] branchID;
    } RobEntry;

    // one retired instruction
    typedef struct packed {
        logic valid;
        Flags flags;
        logic [5:0] nmDst;
        logic [6:0] tagDst;
        SqN sqN;
        logic [29:0] pc;
        logic isBranch;
        logic branchTaken;
        logic [5:0] branchID;
    } CommitUop;

    // true when a is later in program order than b, wraparound safe
    function automatic logic isYounger(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage
